//--- Makefile
# Verilator flow for the multi-word FIFO, every variable can be overridden
VERILATOR  ?= verilator
TOP        ?= mpmp_tb
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
FAIL_MSG   ?= *** FAILED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/mpmp_tb.sv
// self-checking testbench for the multi-word FIFO
// random pushes and pops from a fixed seed, compared every cycle against a
// queue model that follows the FIFO's commit and response delays
`include "mpmp_defs.svh"

module mpmp_tb import mpmp_pkg::*; ();

    localparam int mix_traffic = 0;   // legal and out-of-range requests on both sides
    localparam int fill_only   = 1;
    localparam int overfill    = 2;   // pushes while full, none of them accepted
    localparam int drain_only  = 3;
    localparam int idle_pops   = 4;   // pops against an empty FIFO
    localparam int max_count   = (1 << $bits(count_t)) - 1;

    logic   clk;
    logic   reset_n;
    count_t push;
    lanes_t push_data;
    count_t pop;
    count_t can_push;
    count_t can_pop;
    count_t pop_resp;
    lanes_t pop_data;

    // model state as it stands after the last rising edge
    word_t  words[$];        // stored and in-flight words, oldest first
    int     free_m;          // write-side free count
    int     used_m;          // read-side stored count
    int     push_pipe[3];    // accepted pushes on their way into the banks
    int     pop_pipe[3];     // accepted pops on their way out of the banks
    count_t resp_cnt[6];     // expected pop_resp, index 5 is due now
    lanes_t resp_data[6];
    count_t cur_push;        // request that the DUT samples at the next edge
    count_t cur_pop;
    lanes_t cur_data;
    int     guard;

    mpmp_fifo dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (push),
        .push_data (push_data),
        .can_push  (can_push),
        .pop       (pop),
        .pop_data  (pop_data),
        .pop_resp  (pop_resp),
        .can_pop   (can_pop)
    );

    always #20 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_count(input count_t got, input count_t exp, input string name);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at time %0t: %s is %0d, expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string name,
                              input int lane);
        if (got !== exp) begin
            stop_with_failure($sformatf("error at time %0t: %s[%0d] is 0x%h, expected 0x%h",
                                        $time, name, lane, got, exp));
        end
    endtask

    // a limit output saturates at the lane count
    function automatic count_t limit_of(input int fill);
        return count_t'((fill > `MPMP_LANES) ? `MPMP_LANES : fill);
    endfunction

    function automatic count_t pick_up_to(input count_t limit);
        return count_t'($urandom % (int'(limit) + 1));
    endfunction

    // one rising edge of the model, using the request the DUT just sampled
    task automatic apply_edge();
        int     acc_push;
        int     acc_pop;
        lanes_t popped;
        acc_push = 0;
        acc_pop  = 0;
        popped   = '0;
        if (cur_push != 0 && cur_push <= `MPMP_LANES && cur_push <= free_m) begin
            acc_push = int'(cur_push);
        end
        if (cur_pop != 0 && cur_pop <= `MPMP_LANES && cur_pop <= used_m) begin
            acc_pop = int'(cur_pop);
        end
        for (int j = 0; j < acc_push; j++) begin
            words.push_back(cur_data[j]);              // lane 0 is the oldest word
        end
        for (int j = 0; j < acc_pop; j++) begin
            popped[j] = words.pop_front();
        end
        free_m = free_m + pop_pipe[2] - acc_push;       // pop commits land three edges late
        used_m = used_m + push_pipe[2] - acc_pop;       // so do push commits
        for (int i = 2; i > 0; i--) begin
            push_pipe[i] = push_pipe[i-1];
            pop_pipe[i]  = pop_pipe[i-1];
        end
        push_pipe[0] = acc_push;
        pop_pipe[0]  = acc_pop;
        for (int i = 5; i > 0; i--) begin
            resp_cnt[i]  = resp_cnt[i-1];
            resp_data[i] = resp_data[i-1];
        end
        resp_cnt[0]  = count_t'(acc_pop);
        resp_data[0] = popped;
    endtask

    task automatic check_outputs();
        check_count(can_push, limit_of(free_m), "can_push");
        check_count(can_pop, limit_of(used_m), "can_pop");
        check_count(pop_resp, resp_cnt[5], "pop_resp");
        for (int j = 0; j < int'(resp_cnt[5]); j++) begin
            check_word(pop_data[j], resp_data[5][j], "pop_data", j);
        end
    endtask

    // advance one clock, pick the next request from the model and check at the falling edge
    task automatic run_cycle(input int mode);
        lanes_t data;
        count_t next_push;
        count_t next_pop;
        @(posedge clk);
        apply_edge();
        next_push = '0;
        next_pop  = '0;
        for (int j = 0; j < `MPMP_LANES; j++) begin
            data[j] = word_t'($urandom);
        end
        case (mode)
            mix_traffic: begin
                // one request in eight may be out of range or above the lane count
                next_push = ($urandom % 8 == 0) ? count_t'($urandom) : pick_up_to(limit_of(free_m));
                next_pop  = ($urandom % 8 == 0) ? count_t'($urandom) : pick_up_to(limit_of(used_m));
            end
            fill_only:  next_push = pick_up_to(limit_of(free_m));
            overfill:   next_push = count_t'(1 + $urandom % max_count);
            drain_only: next_pop  = limit_of(used_m);
            default:    next_pop  = count_t'(1 + $urandom % max_count);
        endcase
        cur_push = next_push;
        cur_pop  = next_pop;
        cur_data = data;
        push      <= next_push;
        pop       <= next_pop;
        push_data <= data;
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        void'($urandom(67480));
        clk       = 1'b0;
        reset_n   = 1'b0;
        push      = '0;
        pop       = '0;
        push_data = '0;
        free_m    = `MPMP_SIZE_FIFO;
        used_m    = 0;
        cur_push  = '0;
        cur_pop   = '0;
        cur_data  = '0;
        for (int i = 0; i < 3; i++) begin
            push_pipe[i] = 0;
            pop_pipe[i]  = 0;
        end
        for (int i = 0; i < 6; i++) begin
            resp_cnt[i]  = '0;
            resp_data[i] = '0;
        end
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_count(can_push, '0, "can_push");    // limits only show after the first edge
        check_count(can_pop, '0, "can_pop");
        check_count(pop_resp, '0, "pop_resp");

        for (int n = 0; n < 3000; n++) begin
            run_cycle(mix_traffic);
        end

        // pops still in flight would hand space back during the overfill
        guard = 0;
        while (free_m != 0 || pop_pipe[0] + pop_pipe[1] + pop_pipe[2] != 0) begin
            if (guard == 200) begin
                stop_with_failure("the FIFO did not fill up within 200 cycles");
            end
            run_cycle(fill_only);
            guard++;
        end
        repeat (20) run_cycle(overfill);

        guard = 0;
        while (words.size() != 0 || used_m != 0) begin
            if (guard == 200) begin
                stop_with_failure("the FIFO did not drain within 200 cycles");
            end
            run_cycle(drain_only);
            guard++;
        end

        // wait for the last pop commits to hand the space back
        guard = 0;
        while (free_m != `MPMP_SIZE_FIFO) begin
            if (guard == 50) begin
                stop_with_failure("free space did not return after the drain within 50 cycles");
            end
            run_cycle(idle_pops);
            guard++;
        end
        repeat (20) run_cycle(idle_pops);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- hw/mpmp_admit.sv
// admit stage of the multi-word FIFO
// keeps a write-side free count and a read-side stored count, takes or drops
// whole push and pop requests and registers the can_push and can_pop limits
`include "mpmp_defs.svh"

module mpmp_admit import mpmp_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  count_t      push,
    input  lanes_t      push_data,
    input  count_t      pop,
    input  count_t      push_done,   // words landing in the banks this cycle
    input  count_t      pop_done,    // words leaving the banks this cycle
    output count_t      can_push,
    output count_t      can_pop,
    mpmp_req_if.admit   req
);

    // the write side gives space back only once the read has hit the banks
    fill_t free_cnt;
    // the read side sees words only once they sit in the banks
    fill_t used_cnt;
    fill_t free_next;
    fill_t used_next;
    logic  accept_push;
    logic  accept_pop;

    // a request is taken whole or ignored whole
    assign accept_push = (push != '0) && (push <= `MPMP_LANES) && (push <= free_cnt);
    assign accept_pop  = (pop != '0) && (pop <= `MPMP_LANES) && (pop <= used_cnt);

    always_comb begin
        free_next = free_cnt + fill_t'(pop_done);     // commits from the read path
        used_next = used_cnt + fill_t'(push_done);    // commits from the write path
        if (accept_push) begin
            free_next = free_next - fill_t'(push);
        end
        if (accept_pop) begin
            used_next = used_next - fill_t'(pop);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            free_cnt     <= fill_t'(`MPMP_SIZE_FIFO);
            used_cnt     <= '0;
            can_push     <= '0;
            can_pop      <= '0;
            req.write    <= 1'b0;
            req.push_cnt <= '0;
            req.read     <= 1'b0;
            req.pop_cnt  <= '0;
        end else begin
            free_cnt     <= free_next;
            used_cnt     <= used_next;
            // limits follow the counters just written, saturated at the lane count
            can_push     <= (free_next >= `MPMP_LANES) ? count_t'(`MPMP_LANES)
                                                       : count_t'(free_next);
            can_pop      <= (used_next >= `MPMP_LANES) ? count_t'(`MPMP_LANES)
                                                       : count_t'(used_next);
            req.write    <= accept_push;
            req.push_cnt <= push;
            req.read     <= accept_pop;
            req.pop_cnt  <= pop;
        end
    end

    // payload only travels, the write flag says whether it counts
    always_ff @(posedge clk) begin
        req.wdata <= push_data;
    end

endmodule

//--- hw/mpmp_bank.sv
// one storage bank of the multi-word FIFO
// a small memory with its own write and read addresses and a registered read
`include "mpmp_defs.svh"

module mpmp_bank import mpmp_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  wr_en,
    input  logic  rd_en,
    input  word_t wdata,
    output word_t rdata    // valid one cycle after rd_en
);

    word_t      mem [`MPMP_BANK_DEPTH];
    bank_addr_t wr_addr;
    bank_addr_t rd_addr;

    // each address walks the bank as a ring
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_addr <= '0;
            rd_addr <= '0;
        end else begin
            if (wr_en) begin
                wr_addr <= (wr_addr == `MPMP_BANK_DEPTH - 1) ? '0 : wr_addr + 1'b1;
            end
            if (rd_en) begin
                rd_addr <= (rd_addr == `MPMP_BANK_DEPTH - 1) ? '0 : rd_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wdata;
        end
        if (rd_en) begin
            rdata <= mem[rd_addr];   // holds the last read otherwise
        end
    end

endmodule

//--- hw/mpmp_defs.svh
// sizing of the multi-word FIFO
// data width, capacity, lane count and the per-bank depth derived from them
`ifndef MPMP_DEFS_SVH
`define MPMP_DEFS_SVH

// bits in one data word
`define MPMP_WIDTH_DATA 16

// total number of words the FIFO holds
`define MPMP_SIZE_FIFO 19

// most words moved by one push or one pop, also the number of banks
`define MPMP_LANES 4

// words per bank, the capacity spread over the lanes and rounded up
`define MPMP_BANK_DEPTH ((`MPMP_SIZE_FIFO + `MPMP_LANES - 1) / `MPMP_LANES)

`endif

//--- hw/mpmp_fifo.sv
// multi-word FIFO top level
// pushes and pops of up to the lane count per cycle, stored across one bank
// per lane, pops answered five cycles after the request
`include "mpmp_defs.svh"

module mpmp_fifo import mpmp_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  count_t push,
    input  lanes_t push_data,
    output count_t can_push,
    input  count_t pop,
    output lanes_t pop_data,
    output count_t pop_resp,
    output count_t can_pop
);

    lane_mask_t wr_mask;
    lane_mask_t rd_mask;
    lanes_t     bank_wdata;   // already rotated onto the banks
    lanes_t     bank_rdata;   // still in bank order
    count_t     push_done;
    count_t     pop_done;
    lane_ptr_t  rd_ptr;

    mpmp_req_if req ();

    mpmp_admit u_admit (
        .clk       (clk),
        .reset_n   (reset_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .push_done (push_done),
        .pop_done  (pop_done),
        .can_push  (can_push),
        .can_pop   (can_pop),
        .req       (req.admit)
    );

    mpmp_write_align u_write_align (
        .clk        (clk),
        .reset_n    (reset_n),
        .req        (req.write_side),
        .wr_mask    (wr_mask),
        .bank_wdata (bank_wdata),
        .push_done  (push_done)
    );

    mpmp_read_align u_read_align (
        .clk      (clk),
        .reset_n  (reset_n),
        .req      (req.read_side),
        .rd_mask  (rd_mask),
        .rd_ptr   (rd_ptr),
        .pop_done (pop_done)
    );

    // one bank per lane, each with its own slice of the masks and data
    for (genvar i = 0; i < `MPMP_LANES; i++) begin : gen_bank
        mpmp_bank u_bank (
            .clk     (clk),
            .reset_n (reset_n),
            .wr_en   (wr_mask[i]),
            .rd_en   (rd_mask[i]),
            .wdata   (bank_wdata[i]),
            .rdata   (bank_rdata[i])
        );
    end

    mpmp_read_order u_read_order (
        .clk        (clk),
        .reset_n    (reset_n),
        .bank_rdata (bank_rdata),
        .rd_ptr     (rd_ptr),
        .pop_cnt    (pop_done),   // the commit count doubles as the response count
        .pop_data   (pop_data),
        .pop_resp   (pop_resp)
    );

endmodule

//--- hw/mpmp_if.sv
// accepted request bundle of the multi-word FIFO
// the admit stage registers accepted pushes and pops here, the write and read
// align stages each pick up their own half
interface mpmp_req_if import mpmp_pkg::*; ();

    logic   write;      // the push in push_cnt was accepted
    count_t push_cnt;   // raw push count, only meaningful with write
    lanes_t wdata;      // push payload in request order
    logic   read;       // the pop in pop_cnt was accepted
    count_t pop_cnt;    // raw pop count, only meaningful with read

    modport admit (
        output write,
        output push_cnt,
        output wdata,
        output read,
        output pop_cnt
    );

    modport write_side (
        input write,
        input push_cnt,
        input wdata
    );

    modport read_side (
        input read,
        input pop_cnt
    );

endinterface

//--- hw/mpmp_pkg.sv
// types shared by the multi-word FIFO
// words, lane bundles, counts and the pointer and address types of the banks
`include "mpmp_defs.svh"

package mpmp_pkg;

    typedef logic [`MPMP_WIDTH_DATA-1:0] word_t;

    // one word per lane, lane 0 carries the oldest word
    typedef word_t [`MPMP_LANES-1:0] lanes_t;

    typedef logic [$clog2(`MPMP_LANES + 1)-1:0] count_t;     // 0 up to the lane count
    typedef logic [$clog2(`MPMP_SIZE_FIFO + 1)-1:0] fill_t;  // 0 up to the capacity

    typedef logic [`MPMP_LANES-1:0] lane_mask_t;             // one enable bit per bank

    // a single lane or a single-word bank still gets one bit
    typedef logic [(`MPMP_LANES > 1 ? $clog2(`MPMP_LANES) : 1)-1:0] lane_ptr_t;
    typedef logic [(`MPMP_BANK_DEPTH > 1 ? $clog2(`MPMP_BANK_DEPTH) : 1)-1:0] bank_addr_t;

endpackage

//--- hw/mpmp_read_align.sv
// read path align stages of the multi-word FIFO
// stage 1 turns the pop count into a mask of the low lanes, stage 2 rotates
// it onto the banks from the read pointer and hands that pointer downstream
`include "mpmp_defs.svh"

module mpmp_read_align import mpmp_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    mpmp_req_if.read_side   req,
    output lane_mask_t      rd_mask,    // bank read enables
    output lane_ptr_t       rd_ptr,     // bank holding the oldest word of this pop
    output count_t          pop_done    // words read at the next edge
);

    count_t                  cnt_in;
    lane_mask_t              mask_in;
    lane_mask_t              mask_s1;
    count_t                  cnt_s1;
    lane_ptr_t               ptr;        // bank that gives the next popped word
    logic [$bits(count_t):0] ptr_sum;
    lane_mask_t              mask_rot;

    assign cnt_in = req.read ? req.pop_cnt : '0;

    always_comb begin
        for (int i = 0; i < `MPMP_LANES; i++) begin
            mask_in[i] = (i < cnt_in);
        end
    end

    always_comb begin
        int src;
        for (int b = 0; b < `MPMP_LANES; b++) begin
            src = b + `MPMP_LANES - int'(ptr);   // rotate left by the read pointer
            if (src >= `MPMP_LANES) begin
                src = src - `MPMP_LANES;
            end
            mask_rot[b] = mask_s1[src];
        end
    end

    always_comb begin
        ptr_sum = ptr + cnt_s1;
        if (ptr_sum >= `MPMP_LANES) begin
            ptr_sum = ptr_sum - `MPMP_LANES;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mask_s1  <= '0;
            cnt_s1   <= '0;
            rd_mask  <= '0;
            rd_ptr   <= '0;
            pop_done <= '0;
            ptr      <= '0;
        end else begin
            mask_s1  <= mask_in;
            cnt_s1   <= cnt_in;
            rd_mask  <= mask_rot;
            rd_ptr   <= ptr;                    // value before this pop advances it
            pop_done <= cnt_s1;
            ptr      <= lane_ptr_t'(ptr_sum);
        end
    end

endmodule

//--- hw/mpmp_read_order.sv
// output stages of the multi-word FIFO
// registers the bank outputs, rotates them back so lane 0 holds the oldest
// word and drives pop_data with its word count on pop_resp
`include "mpmp_defs.svh"

module mpmp_read_order import mpmp_pkg::*; (
    input  logic      clk,
    input  logic      reset_n,
    input  lanes_t    bank_rdata,
    input  lane_ptr_t rd_ptr,
    input  count_t    pop_cnt,
    output lanes_t    pop_data,   // lanes at and above pop_resp are stale
    output count_t    pop_resp    // zero in every cycle without a pop
);

    lane_ptr_t ptr_d;    // lines up with the bank read edge
    count_t    cnt_d;
    lane_ptr_t ptr_q;    // lines up with the registered bank data
    count_t    cnt_q;
    lanes_t    rdata_q;
    lanes_t    data_ord;

    // rotate right, output lane j comes from bank (j + ptr) mod lanes
    always_comb begin
        int src;
        for (int j = 0; j < `MPMP_LANES; j++) begin
            src = j + int'(ptr_q);
            if (src >= `MPMP_LANES) begin
                src = src - `MPMP_LANES;
            end
            data_ord[j] = rdata_q[src];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ptr_d    <= '0;
            cnt_d    <= '0;
            ptr_q    <= '0;
            cnt_q    <= '0;
            pop_resp <= '0;
        end else begin
            ptr_d    <= rd_ptr;
            cnt_d    <= pop_cnt;
            ptr_q    <= ptr_d;
            cnt_q    <= cnt_d;
            pop_resp <= cnt_q;
        end
    end

    always_ff @(posedge clk) begin
        rdata_q  <= bank_rdata;
        pop_data <= data_ord;
    end

endmodule

//--- hw/mpmp_write_align.sv
// write path align stages of the multi-word FIFO
// stage 1 turns the push count into a mask of the low lanes, stage 2 rotates
// mask and data onto the banks starting at the write pointer
`include "mpmp_defs.svh"

module mpmp_write_align import mpmp_pkg::*; (
    input  logic            clk,
    input  logic            reset_n,
    mpmp_req_if.write_side  req,
    output lane_mask_t      wr_mask,      // bank write enables
    output lanes_t          bank_wdata,   // data already placed on its bank
    output count_t          push_done     // words written at the next edge
);

    count_t                 cnt_in;
    lane_mask_t             mask_in;
    lane_mask_t             mask_s1;
    lanes_t                 data_s1;
    count_t                 cnt_s1;
    lane_ptr_t              wr_ptr;       // bank that takes the next pushed word
    logic [$bits(count_t):0] ptr_sum;
    lane_mask_t             mask_rot;
    lanes_t                 data_rot;

    assign cnt_in = req.write ? req.push_cnt : '0;   // a dropped push moves nothing

    always_comb begin
        for (int i = 0; i < `MPMP_LANES; i++) begin
            mask_in[i] = (i < cnt_in);   // thermometer over the low lanes
        end
    end

    // lane j of the request lands on bank (j + wr_ptr) mod lanes
    always_comb begin
        int src;
        for (int b = 0; b < `MPMP_LANES; b++) begin
            src = b + `MPMP_LANES - int'(wr_ptr);
            if (src >= `MPMP_LANES) begin
                src = src - `MPMP_LANES;
            end
            mask_rot[b] = mask_s1[src];
            data_rot[b] = data_s1[src];
        end
    end

    always_comb begin
        ptr_sum = wr_ptr + cnt_s1;
        if (ptr_sum >= `MPMP_LANES) begin
            ptr_sum = ptr_sum - `MPMP_LANES;   // wrap around the banks
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mask_s1   <= '0;
            cnt_s1    <= '0;
            wr_mask   <= '0;
            push_done <= '0;
            wr_ptr    <= '0;
        end else begin
            mask_s1   <= mask_in;
            cnt_s1    <= cnt_in;
            wr_mask   <= mask_rot;
            push_done <= cnt_s1;
            wr_ptr    <= lane_ptr_t'(ptr_sum);   // unchanged when cnt_s1 is zero
        end
    end

    always_ff @(posedge clk) begin
        data_s1    <= req.wdata;
        bank_wdata <= data_rot;
    end

endmodule

//--- verilog.f
+incdir+hw
hw/mpmp_pkg.sv
hw/mpmp_if.sv
hw/mpmp_bank.sv
hw/mpmp_admit.sv
hw/mpmp_write_align.sv
hw/mpmp_read_align.sv
hw/mpmp_read_order.sv
hw/mpmp_fifo.sv
bench/mpmp_tb.sv
